// File: compile.f
hdl/group_norm_pkg.sv
hdl/norm_sequencer.sv
hdl/beat_counter.sv
hdl/group_buffer.sv
hdl/moment_accumulator.sv
hdl/isqrt_lut.sv
hdl/norm_scale_lanes.sv
hdl/group_norm_2d.sv
verification/group_norm_checker.sv
verification/tb_group_norm_2d.sv

// File: hdl/beat_counter.sv
/*
  Beat counter
  Beat index within one pass, with last-beat flag and wrap
*/

`timescale 1ns/1ps
`default_nettype none

module beat_counter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            clear,
    input  logic                            step,
    output logic [group_norm_pkg::beat_w-1:0] beat_idx,
    output logic                            last_beat
);
    import group_norm_pkg::*;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            beat_idx <= '0;
        end else if (step) begin
            beat_idx <= last_beat ? '0 : beat_idx + 1'b1;
        end
    end

    assign last_beat = (beat_idx == beat_w'(group_beats - 1));

endmodule

`default_nettype wire

// File: hdl/group_buffer.sv
/*
  Group buffer
  Register store for every beat of the current group, written during
  load and replayed for the variance and output passes
*/

`timescale 1ns/1ps
`default_nettype none

module group_buffer (
    input  logic                                                clk,
    input  logic                                                wr_en,
    input  logic [group_norm_pkg::lanes*group_norm_pkg::in_w-1:0] wr_data,
    input  logic [group_norm_pkg::beat_w-1:0]                   idx,
    output logic [group_norm_pkg::lanes*group_norm_pkg::in_w-1:0] rd_data
);
    import group_norm_pkg::*;

    logic [lanes*in_w-1:0] beats [group_beats];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            beats[idx] <= wr_data;
        end
    end

    // Read port is asynchronous
    assign rd_data = beats[idx];

endmodule

`default_nettype wire

// File: hdl/group_norm_2d.sv
/*
  Streaming group normalization
  Buffers one group, forms mean and variance, looks up the inverse root
  and replays the normalized beats in arrival order
*/

`timescale 1ns/1ps
`default_nettype none

module group_norm_2d (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [group_norm_pkg::lanes*group_norm_pkg::in_w-1:0]  in_data,
    input  logic                                                   in_valid,
    output logic                                                   in_ready,
    output logic [group_norm_pkg::lanes*group_norm_pkg::out_w-1:0] out_data,
    output logic                                                   out_valid,
    input  logic                                                   out_ready
);
    import group_norm_pkg::*;

    logic                  load_en;
    logic                  var_en;
    logic                  root_en;
    logic                  out_en;
    logic                  clear;
    logic                  acc_clear;
    logic [beat_w-1:0]     beat_idx;
    logic                  last_beat;
    logic                  in_hs;
    logic                  out_hs;
    logic                  step;
    logic [beat_w-1:0]     buf_idx;
    logic [lanes*in_w-1:0] rd_data;
    logic [in_w-1:0]       mean;
    logic [var_w-1:0]      variance;
    logic [isqrt_w-1:0]    inv_root;

    assign in_hs  = load_en && in_valid;
    assign out_hs = out_valid && out_ready;
    assign step   = in_hs || var_en || out_hs;

    // On an output handshake the register takes the following beat
    assign buf_idx = out_hs ? beat_idx + 1'b1 : beat_idx;

    norm_sequencer u_norm_sequencer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .last_beat (last_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .load_en   (load_en),
        .var_en    (var_en),
        .root_en   (root_en),
        .out_en    (out_en),
        .clear     (clear),
        .acc_clear (acc_clear)
    );

    beat_counter u_beat_counter (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .step      (step),
        .beat_idx  (beat_idx),
        .last_beat (last_beat)
    );

    group_buffer u_group_buffer (
        .clk     (clk),
        .wr_en   (in_hs),
        .wr_data (in_data),
        .idx     (buf_idx),
        .rd_data (rd_data)
    );

    moment_accumulator u_moment_accumulator (
        .clk       (clk),
        .rst       (rst),
        .acc_clear (acc_clear),
        .sum_en    (in_hs),
        .sq_en     (var_en),
        .sum_data  (in_data),
        .sq_data   (rd_data),
        .mean      (mean),
        .variance  (variance)
    );

    isqrt_lut u_isqrt_lut (
        .clk      (clk),
        .rst      (rst),
        .root_en  (root_en),
        .variance (variance),
        .inv_root (inv_root)
    );

    norm_scale_lanes u_norm_scale_lanes (
        .clk      (clk),
        .rst      (rst),
        .load     (out_en),
        .beat     (rd_data),
        .mean     (mean),
        .inv_root (inv_root),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

// File: hdl/group_norm_pkg.sv
/*
  Group normalization shared constants
  Lane and beat counts, fixed-point widths, phase codes and the
  inverse square root table used by the group norm datapath
*/

`default_nettype none

package group_norm_pkg;

    // Compute dimension 2 x 2, four beats per group
    localparam int lanes       = 4;
    localparam int group_beats = 4;
    localparam int beat_w      = 2;
    localparam int group_vals  = lanes * group_beats;
    localparam int div_shift   = $clog2(group_vals);

    // Fixed-point formats
    localparam int in_w       = 8;
    localparam int in_frac    = 4;
    localparam int out_w      = 8;
    localparam int out_frac   = 4;
    localparam int diff_w     = 9;
    localparam int sum_w      = 12;
    localparam int sq_w       = 22;
    localparam int var_w      = 16;
    localparam int var_frac   = 8;
    localparam int isqrt_w    = 16;
    localparam int isqrt_frac = 8;

    // Squares carry 2 * in_frac fraction bits, the variance keeps var_frac
    localparam int var_shift  = div_shift + 2 * in_frac - var_frac;
    localparam int norm_shift = isqrt_frac + in_frac - out_frac;

    // Table entry at k = 0 sits this many bits above Q8.8
    localparam int isqrt_shift0  = 4;
    localparam int isqrt_entries = 32;
    localparam int isqrt_idx_w   = 5;

    // Sequencer phases
    localparam int ph_w = 2;
    localparam logic [ph_w-1:0] ph_load = 2'd0;
    localparam logic [ph_w-1:0] ph_var  = 2'd1;
    localparam logic [ph_w-1:0] ph_root = 2'd2;
    localparam logic [ph_w-1:0] ph_out  = 2'd3;

    // floor(2^16 / sqrt((i + 0.5) * 2^11)), entries below 8 never addressed
    localparam logic [isqrt_w-1:0] isqrt_table [isqrt_entries] = '{
        16'd0,   16'd0,   16'd0,   16'd0,   16'd0,   16'd0,   16'd0,   16'd0,
        16'd496, 16'd469, 16'd446, 16'd427, 16'd409, 16'd394, 16'd380, 16'd367,
        16'd356, 16'd346, 16'd336, 16'd327, 16'd319, 16'd312, 16'd305, 16'd298,
        16'd292, 16'd286, 16'd281, 16'd276, 16'd271, 16'd266, 16'd262, 16'd258
    };

endpackage

`default_nettype wire

// File: hdl/isqrt_lut.sv
/*
  Inverse square root lookup
  Normalizes the Q8.8 variance by an even shift, looks up the table and
  rescales the entry, holding the result for the output pass
*/

`timescale 1ns/1ps
`default_nettype none

module isqrt_lut (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               root_en,
    input  logic [group_norm_pkg::var_w-1:0]   variance,
    output logic [group_norm_pkg::isqrt_w-1:0] inv_root
);
    import group_norm_pkg::*;

    logic [2:0]             k;
    logic                   found;
    logic [var_w-1:0]       norm_v;
    logic [isqrt_idx_w-1:0] lut_idx;
    logic [isqrt_w-1:0]     entry;
    logic [isqrt_w+3:0]     scaled;
    logic [isqrt_w-1:0]     root_d;

    // Smallest even shift that sets bit 15 or bit 14
    always_comb begin
        k     = '0;
        found = 1'b0;
        for (int s = 0; s < var_w / 2; s++) begin
            if (!found && (variance[var_w-1-2*s] || variance[var_w-2-2*s])) begin
                k     = 3'(s);
                found = 1'b1;
            end
        end
    end

    assign norm_v  = variance << {k, 1'b0};
    assign lut_idx = norm_v[var_w-1 -: isqrt_idx_w];
    assign entry   = isqrt_table[lut_idx];

    always_comb begin
        if (k < isqrt_shift0) begin
            scaled = {4'b0, entry} >> (isqrt_shift0 - k);
        end else begin
            scaled = {4'b0, entry} << (k - isqrt_shift0);
        end
        // Zero variance and overflow both saturate
        if (!found || |scaled[isqrt_w+3:isqrt_w]) begin
            root_d = '1;
        end else begin
            root_d = scaled[isqrt_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inv_root <= '0;
        end else if (root_en) begin
            inv_root <= root_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/moment_accumulator.sv
/*
  Moment accumulator
  Sums the group values during load and the squared differences from
  the mean during the variance pass, giving floor mean and clamped variance
*/

`timescale 1ns/1ps
`default_nettype none

module moment_accumulator (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                acc_clear,
    input  logic                                                sum_en,
    input  logic                                                sq_en,
    input  logic [group_norm_pkg::lanes*group_norm_pkg::in_w-1:0] sum_data,
    input  logic [group_norm_pkg::lanes*group_norm_pkg::in_w-1:0] sq_data,
    output logic [group_norm_pkg::in_w-1:0]                     mean,
    output logic [group_norm_pkg::var_w-1:0]                    variance
);
    import group_norm_pkg::*;

    logic signed [sum_w-1:0] sum_q;
    logic [sq_w-1:0]         sq_q;
    logic signed [sum_w-1:0] beat_sum;
    logic [sq_w-1:0]         beat_sq;
    logic [sq_w-1:0]         var_full;

    // Lane sums of the current beat
    always_comb begin
        beat_sum = '0;
        beat_sq  = '0;
        for (int i = 0; i < lanes; i++) begin
            logic signed [diff_w-1:0] d;
            d        = diff_w'($signed(sq_data[i*in_w +: in_w])) - diff_w'($signed(mean));
            beat_sum = beat_sum + sum_w'($signed(sum_data[i*in_w +: in_w]));
            beat_sq  = beat_sq + sq_w'(d * d);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || acc_clear) begin
            sum_q <= '0;
            sq_q  <= '0;
        end else begin
            if (sum_en) begin
                sum_q <= sum_q + beat_sum;
            end
            if (sq_en) begin
                sq_q <= sq_q + beat_sq;
            end
        end
    end

    // Arithmetic shift gives the floor for negative sums
    assign mean     = in_w'(sum_q >>> div_shift);
    assign var_full = sq_q >> var_shift;

    always_comb begin
        if (|var_full[sq_w-1:var_w]) begin
            variance = '1;
        end else begin
            variance = var_full[var_w-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/norm_scale_lanes.sv
/*
  Normalize and scale lanes
  Per lane (x - mean) * inv_root, floored to the output format and
  saturated, into the output register
*/

`timescale 1ns/1ps
`default_nettype none

module norm_scale_lanes (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 load,
    input  logic [group_norm_pkg::lanes*group_norm_pkg::in_w-1:0]  beat,
    input  logic [group_norm_pkg::in_w-1:0]                      mean,
    input  logic [group_norm_pkg::isqrt_w-1:0]                   inv_root,
    output logic [group_norm_pkg::lanes*group_norm_pkg::out_w-1:0] out_data
);
    import group_norm_pkg::*;

    logic [lanes*out_w-1:0] scaled_d;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            logic signed [diff_w-1:0]       diff;
            logic signed [diff_w+isqrt_w:0] prod;
            logic signed [diff_w+isqrt_w:0] shifted;
            diff    = diff_w'($signed(beat[i*in_w +: in_w])) - diff_w'($signed(mean));
            prod    = diff * $signed({1'b0, inv_root});
            // Floor by arithmetic shift
            shifted = prod >>> norm_shift;
            if (shifted > (2 ** (out_w - 1)) - 1) begin
                scaled_d[i*out_w +: out_w] = {1'b0, {(out_w - 1){1'b1}}};
            end else if (shifted < -(2 ** (out_w - 1))) begin
                scaled_d[i*out_w +: out_w] = {1'b1, {(out_w - 1){1'b0}}};
            end else begin
                scaled_d[i*out_w +: out_w] = shifted[out_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_data <= '0;
        end else if (load) begin
            out_data <= scaled_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/norm_sequencer.sv
/*
  Group norm sequencer
  Steps one group through load, variance, root and output phases and
  owns the input and output handshake flags
*/

`timescale 1ns/1ps
`default_nettype none

module norm_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic out_ready,
    input  logic last_beat,
    output logic in_ready,
    output logic out_valid,
    output logic load_en,
    output logic var_en,
    output logic root_en,
    output logic out_en,
    output logic clear,
    output logic acc_clear
);
    import group_norm_pkg::*;

    logic [ph_w-1:0] phase;
    logic            out_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= ph_load;
            out_valid <= 1'b0;
        end else begin
            case (phase)
                ph_load: begin
                    if (in_valid && last_beat) begin
                        phase <= ph_var;
                    end
                end
                // Fixed length pass over the buffered beats
                ph_var: begin
                    if (last_beat) begin
                        phase <= ph_root;
                    end
                end
                ph_root: begin
                    phase <= ph_out;
                end
                ph_out: begin
                    // First cycle primes the output register
                    if (!out_valid) begin
                        out_valid <= 1'b1;
                    end else if (out_done) begin
                        out_valid <= 1'b0;
                        phase     <= ph_load;
                    end
                end
                default: begin
                    phase <= ph_load;
                end
            endcase
        end
    end

    assign out_done  = out_valid && out_ready && last_beat;

    assign load_en   = (phase == ph_load);
    assign var_en    = (phase == ph_var);
    assign root_en   = (phase == ph_root);
    assign in_ready  = load_en;

    // Output register loads when empty or when its beat is taken
    assign out_en    = (phase == ph_out) && (!out_valid || out_ready);

    assign clear     = root_en || out_done;
    assign acc_clear = out_done;

endmodule

`default_nettype wire

// File: verification/group_norm_checker.sv
/*
  Group norm protocol checker
  Concurrent assertions on the handshake and phase rules,
  bound into every group_norm_2d instance
*/

`timescale 1ns/1ps
`default_nettype none

module group_norm_checker (
    input logic                                                   clk,
    input logic                                                   rst,
    input logic                                                   in_ready,
    input logic                                                   out_valid,
    input logic                                                   out_ready,
    input logic [group_norm_pkg::lanes*group_norm_pkg::out_w-1:0] out_data
);
    int unsigned fail_count = 0;

    // Load and output phases never overlap
    a_ready_valid_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(in_ready && out_valid)
    ) else begin
        $error("in_ready and out_valid high in the same cycle");
        fail_count++;
    end

    // A stalled output beat keeps its data and its valid
    a_out_hold: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else begin
        $error("output beat changed or dropped while stalled");
        fail_count++;
    end

    // Sequencer sits in load with no output pending during reset
    a_reset_state: assert property (
        @(posedge clk) rst |=> (in_ready && !out_valid)
    ) else begin
        $error("in_ready or out_valid not at reset value");
        fail_count++;
    end

    // Load reopens only right after the final output handshake
    a_reload_after_drain: assert property (
        @(posedge clk) disable iff (rst)
        $rose(in_ready) |-> $past(out_valid && out_ready)
    ) else begin
        $error("in_ready rose without a preceding output handshake");
        fail_count++;
    end

endmodule

bind group_norm_2d group_norm_checker u_group_norm_checker (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

`default_nettype wire

// File: verification/tb_group_norm_2d.sv
/*
  Testbench for group_norm_2d
  LFSR stimulus, a reference model of the group statistics and the
  normalized output, and per-test reporting
*/

`timescale 1ns/1ps
`default_nettype none

module tb_group_norm_2d;
    import group_norm_pkg::*;

    localparam int total_groups = 9;
    localparam int reset_cycles = 10;
    localparam int cycle_limit  = reset_cycles + total_groups * (3 * group_beats + 20);

    logic                   clk = 1'b0;
    logic                   rst;
    logic [lanes*in_w-1:0]  in_data;
    logic                   in_valid;
    logic                   in_ready;
    logic [lanes*out_w-1:0] out_data;
    logic                   out_valid;
    logic                   out_ready;

    logic signed [in_w-1:0] grp [group_vals];
    logic [lanes*out_w-1:0] exp_q [$];
    logic [15:0]            lfsr_state = 16'd35;
    int                     errors = 0;
    int                     checks = 0;
    int                     tests = 0;
    int                     cycle_cnt = 0;
    int                     in_cnt = 0;
    int                     out_cnt = 0;
    int                     wait_cnt = 0;
    bit                     busy = 1'b0;
    bit                     waiting = 1'b0;

    group_norm_2d u_group_norm_2d (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Division rounding toward minus infinity, b positive
    function automatic int floor_div(input int a, input int b);
        int q;
        q = a / b;
        if ((a % b != 0) && (a < 0)) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic int total_errors();
        return errors + int'(u_group_norm_2d.u_group_norm_checker.fail_count);
    endfunction

    // Reference model, queues the expected output beats of grp
    task automatic push_expected();
        int sum;
        int mean;
        int sq;
        int var_q;
        int k;
        int norm;
        int root;
        int y;
        logic [lanes*out_w-1:0] word;
        sum = 0;
        for (int i = 0; i < group_vals; i++) begin
            sum += grp[i];
        end
        mean = floor_div(sum, group_vals);
        sq = 0;
        for (int i = 0; i < group_vals; i++) begin
            sq += (grp[i] - mean) * (grp[i] - mean);
        end
        var_q = floor_div(sq, group_vals);
        if (var_q > 65535) begin
            var_q = 65535;
        end
        if (var_q == 0) begin
            root = 65535;
        end else begin
            k = 0;
            norm = var_q;
            while (norm < 16384) begin
                norm = norm * 4;
                k++;
            end
            root = isqrt_table[norm >> 11];
            root = (k < 4) ? (root >> (4 - k)) : (root << (k - 4));
            if (root > 65535) begin
                root = 65535;
            end
        end
        for (int b = 0; b < group_beats; b++) begin
            for (int l = 0; l < lanes; l++) begin
                y = floor_div((grp[b*lanes+l] - mean) * root, 256);
                y = (y > 127) ? 127 : ((y < -128) ? -128 : y);
                word[l*out_w +: out_w] = out_w'(y);
            end
            exp_q.push_back(word);
        end
    endtask

    task automatic drive_group(input bit gaps);
        bit accepted;
        int gap;
        for (int b = 0; b < group_beats; b++) begin
            if (gaps) begin
                gap = int'(take_bits(2));
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            for (int l = 0; l < lanes; l++) begin
                in_data[l*in_w +: in_w] = grp[b*lanes+l];
            end
            in_valid = 1'b1;
            do begin
                @(negedge clk);
                accepted = in_ready;
                @(posedge clk);
                #1;
            end while (!accepted);
            in_valid = 1'b0;
        end
    endtask

    task automatic drain_outputs(input bit backpressure);
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #1;
            out_ready = backpressure ? (take_bits(1) != 0) : 1'b1;
        end
        out_ready = 1'b1;
    endtask

    task automatic run_group(input bit gaps, input bit backpressure);
        push_expected();
        drive_group(gaps);
        drain_outputs(backpressure);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("Test %0d %s: %s", tests, name,
                 (total_errors() == err_start) ? "ok" : "errors seen");
    endtask

    task automatic fill_random();
        for (int i = 0; i < group_vals; i++) begin
            grp[i] = in_w'(take_bits(8));
        end
    endtask

    // Monitor at the falling edge, where every signal is settled
    always @(negedge clk) begin
        logic [lanes*out_w-1:0] exp_word;
        if (!rst) begin
            if (busy) begin
                checks++;
                assert (!in_ready) else begin
                    $display("Time %0t: in_ready high while a group is in flight", $time);
                    errors++;
                end
            end
            if (waiting) begin
                if (out_valid) begin
                    checks++;
                    assert (wait_cnt <= group_beats + 2) else begin
                        $display("Time %0t: first output came %0d cycles after last input",
                                 $time, wait_cnt);
                        errors++;
                    end
                    waiting = 1'b0;
                end else begin
                    wait_cnt++;
                end
            end
            if (in_valid && in_ready) begin
                if (in_cnt == group_beats - 1) begin
                    busy     = 1'b1;
                    waiting  = 1'b1;
                    wait_cnt = 0;
                end
                in_cnt = (in_cnt + 1) % group_beats;
            end
            if (out_valid && out_ready) begin
                checks++;
                assert (exp_q.size() > 0) else begin
                    $display("Time %0t: output beat with no expected beat left", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_word = exp_q.pop_front();
                    checks++;
                    assert (out_data === exp_word) else begin
                        $display("CHECK FAILED time %0t out_data got %h expected %h",
                                 $time, out_data, exp_word);
                        errors++;
                    end
                end
                if (out_cnt == group_beats - 1) begin
                    busy = 1'b0;
                end
                out_cnt = (out_cnt + 1) % group_beats;
            end
        end
    end

    initial begin
        int err_start;
        rst       = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;

        err_start = total_errors();
        fill_random();
        run_group(1'b0, 1'b0);
        report_test("random group", err_start);

        err_start = total_errors();
        for (int i = 0; i < group_vals; i++) begin
            grp[i] = 8'sd37;
        end
        run_group(1'b0, 1'b0);
        report_test("constant group", err_start);

        err_start = total_errors();
        for (int i = 0; i < group_vals; i++) begin
            grp[i] = (take_bits(1) != 0) ? 8'sd127 : -8'sd128;
        end
        run_group(1'b0, 1'b0);
        // Near constant at full scale, the lone step saturates the output
        for (int i = 0; i < group_vals; i++) begin
            grp[i] = (i == 5) ? 8'sd126 : 8'sd127;
        end
        run_group(1'b0, 1'b0);
        report_test("extreme values", err_start);

        err_start = total_errors();
        fill_random();
        run_group(1'b0, 1'b1);
        report_test("output back-pressure", err_start);

        err_start = total_errors();
        fill_random();
        run_group(1'b1, 1'b0);
        report_test("input gaps", err_start);

        err_start = total_errors();
        repeat (3) begin
            fill_random();
            run_group(1'b0, 1'b0);
        end
        report_test("groups in a row", err_start);

        $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
